// File: tb/hisGolden.txt
# C clear pulse | S value gap | R value gap count | E name frames
# after E: 3 rows (pixel 0..2) of 8 counts (bin 0..7)
E resetState 0
0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0
C S 108 0 S 511 0 S 1023 0 S 1023 0 S 200 0 S 90 0
E pairing 1
0 0 0 0 1 0 0 0
0 0 0 0 0 0 0 1
0 0 1 0 0 0 0 0
C S 64 0 S 64 0 S 0 0 S 0 0 S 1023 0 S 1023 0
S 384 0 S 384 0 S 1000 0 S 24 0 S 1023 0 S 513 0
E edges 2
0 1 0 0 0 1 0 0
1 0 0 0 0 0 1 0
0 0 0 0 0 0 0 2
C S 108 1 S 511 3 S 1023 0 S 1023 2 S 200 5 S 90 1
E gaps 1
0 0 0 0 1 0 0 0
0 0 0 0 0 0 0 1
0 0 1 0 0 0 0 0
C S 108 0 S 511 0 S 1023 0 S 1023 0 S 200 0 S 90 0
S 300 0 S 300 0 S 50 0 S 50 0 S 700 0 S 700 0
S 108 0 S 511 0 S 1023 0 S 1023 0 S 200 0 S 90 0
E frames 3
0 0 0 0 3 0 0 0
1 0 0 0 0 0 0 2
0 0 2 0 0 0 1 0
S 999 0 C S 300 0 S 300 0 S 50 0 S 50 0 S 700 0 S 700 0
E restartAfterClear 1
0 0 0 0 1 0 0 0
1 0 0 0 0 0 0 0
0 0 0 0 0 0 1 0
C R 100 0 1800
E saturation 300
0 255 0 0 0 0 0 0
0 255 0 0 0 0 0 0
0 255 0 0 0 0 0 0

// File: list.f
source/hisPkg.sv
source/pixelIf.sv
source/binIf.sv
source/sampleSequencer.sv
source/binClassifier.sv
source/histogramAccumulator.sv
source/hisBuilder.sv
tb/hisBuilderTB.sv

// File: run.sh
#!/bin/sh
# compile with Verilator, run from the project root, decide on the output
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f --top-module hisBuilderTB -o hisSim \
    || { echo "run.sh: build failed"; exit 1; }

out=$(./obj_dir/hisSim)
echo "$out"

echo "$out" | grep -qx "Testbench passed" \
    && echo "run.sh: simulation ok" \
    || { echo "run.sh: simulation not ok"; exit 1; }

// File: tb/hisBuilderTB.sv
`timescale 1ns/10ps
`default_nettype none

module hisBuilderTB import hisPkg::*; ();

    localparam int WAIT_LIMIT = 50; // cycles allowed for the last frameDone
    localparam int NAME_W     = 8 * 24;

    logic               clk;
    logic               rstN;
    logic               clear;
    logic               wrEn;
    logic [NP-1:0]      data;
    logic [PIXEL_W-1:0] rdPixel;
    logic [BIN_W-1:0]   rdBin;
    logic [COUNT_W-1:0] rdCount;
    logic               frameDone;

    int fd;
    int frameCount = 0; // frameDone pulses seen since reset
    int valueErrors = 0;
    int otherErrors = 0;
    int checkCount = 0;

    hisBuilder hisBuilder_i (
        .clk       (clk),
        .rstN      (rstN),
        .clear     (clear),
        .wrEn      (wrEn),
        .data      (data),
        .rdPixel   (rdPixel),
        .rdBin     (rdBin),
        .rdCount   (rdCount),
        .frameDone (frameDone)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // frameDone as registered on the previous rising edge
    always @(posedge clk) begin
        if (frameDone) begin
            frameCount = frameCount + 1;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stimulus
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic pulseClear();
        clear = 1'b1;
        @(negedge clk);
        clear = 1'b0;
    endtask

    task automatic sendSample(input int value, input int gap);
        wrEn = 1'b1;
        data = NP'(value);
        @(negedge clk);
        wrEn = 1'b0;
        repeat (gap) @(negedge clk); // idle cycles between samples
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // checking
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic waitFrames(input int target, input logic [NAME_W-1:0] testName);
        int waited;
        waited = 0;
        while (frameCount < target && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (frameCount < target) begin
            $display("timeout in %0s: frameDone did not arrive within %0d cycles",
                     testName, WAIT_LIMIT);
            otherErrors++;
        end
    endtask

    task automatic checkTable(input logic [NAME_W-1:0] testName, input int expFrames,
                              input int frameBase);
        int expCount;
        int actual;
        waitFrames(frameBase + expFrames, testName);
        repeat (2) @(negedge clk); // let the last hit settle
        assert (frameCount - frameBase == expFrames) else begin
            $display("FAILED %0s frameDone pulses expected %0d actual %0d",
                     testName, expFrames, frameCount - frameBase);
            valueErrors++;
        end
        for (int p = 0; p < PIXEL_NUM; p++) begin
            for (int b = 0; b < BIN_NUM; b++) begin
                if ($fscanf(fd, "%d", expCount) != 1) begin
                    $display("golden file ends inside the table of %0s", testName);
                    otherErrors++;
                end
                rdPixel = PIXEL_W'(p);
                rdBin   = BIN_W'(b);
                @(negedge clk); // one cycle read latency
                actual = int'(rdCount);
                assert (actual == expCount) else begin
                    $display("FAILED %0s pixel %0d bin %0d expected %0d actual %0d",
                             testName, p, b, expCount, actual);
                    valueErrors++;
                end
            end
        end
        checkCount++;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // golden file records
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic runGolden();
        logic [7:0]        kind;
        logic [NAME_W-1:0] testName;
        logic [8*80-1:0]   line;
        int                value;
        int                gap;
        int                count;
        int                frames;
        int                frameBase;
        int                code;
        bit                done;
        frameBase = 0;
        done      = 1'b0;
        while (!done) begin
            code = $fscanf(fd, " %c", kind);
            if (code != 1) begin
                done = 1'b1; // end of file
            end else begin
                case (kind)
                    "#": code = $fgets(line, fd);
                    "C": pulseClear();
                    "S": begin
                        code = $fscanf(fd, "%d %d", value, gap);
                        sendSample(value, gap);
                    end
                    "R": begin
                        code = $fscanf(fd, "%d %d %d", value, gap, count);
                        repeat (count) sendSample(value, gap);
                    end
                    "E": begin
                        code = $fscanf(fd, "%s %d", testName, frames);
                        checkTable(testName, frames, frameBase);
                        frameBase = frameCount;
                    end
                    default: begin
                        $display("unknown record kind '%c' in golden file", kind);
                        otherErrors++;
                    end
                endcase
            end
        end
    endtask

    initial begin
        rstN    = 1'b0;
        clear   = 1'b0;
        wrEn    = 1'b0;
        data    = '0;
        rdPixel = '0;
        rdBin   = '0;
        repeat (2) @(negedge clk);
        rstN = 1'b1;

        fd = $fopen("tb/hisGolden.txt", "r");
        if (fd == 0) begin
            $display("could not open tb/hisGolden.txt");
            otherErrors++;
        end else begin
            runGolden();
            $fclose(fd);
        end
        if (checkCount == 0) begin
            $display("no table was checked");
            otherErrors++;
        end

        $display("errors: %0d wrong values, %0d other failures, %0d tables checked",
                 valueErrors, otherErrors, checkCount);
        if (valueErrors == 0 && otherErrors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: source/hisBuilder.sv
`timescale 1ns/10ps
`default_nettype none

module hisBuilder import hisPkg::*; (
    input  wire                clk,
    input  wire                rstN,
    input  wire                clear,     // starts a new acquisition
    input  wire                wrEn,      // sample strobe
    input  wire [NP-1:0]       data,
    input  wire [PIXEL_W-1:0]  rdPixel,
    input  wire [BIN_W-1:0]    rdBin,
    output logic [COUNT_W-1:0] rdCount,
    output logic               frameDone
);

    pixelIf pixelBus ();
    binIf   binBus ();

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // pipeline: pair, classify, count
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    sampleSequencer sampleSequencer_i (
        .clk   (clk),
        .rstN  (rstN),
        .clear (clear),
        .wrEn  (wrEn),
        .data  (data),
        .pOut  (pixelBus.src)
    );

    binClassifier binClassifier_i (
        .clk  (clk),
        .rstN (rstN),
        .pIn  (pixelBus.dst),
        .bOut (binBus.src)
    );

    histogramAccumulator histogramAccumulator_i (
        .clk       (clk),
        .rstN      (rstN),
        .clear     (clear),
        .bIn       (binBus.dst),
        .rdPixel   (rdPixel),
        .rdBin     (rdBin),
        .rdCount   (rdCount),
        .frameDone (frameDone)
    );

endmodule

`default_nettype wire

// File: source/histogramAccumulator.sv
`timescale 1ns/10ps
`default_nettype none

module histogramAccumulator import hisPkg::*; (
    input  wire                clk,
    input  wire                rstN,
    input  wire                clear,
    binIf.dst                  bIn,
    input  wire [PIXEL_W-1:0]  rdPixel,
    input  wire [BIN_W-1:0]    rdBin,
    output logic [COUNT_W-1:0] rdCount,
    output logic               frameDone
);

    // one counter per pixel and bin
    logic [COUNT_W-1:0] counts [PIXEL_NUM][BIN_NUM];
    logic [COUNT_W-1:0] rdValue;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // counter update
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (!rstN || clear) begin
            // a hit arriving with clear is lost
            for (int p = 0; p < PIXEL_NUM; p++) begin
                for (int b = 0; b < BIN_NUM; b++) begin
                    counts[p][b] <= '0;
                end
            end
        end else if (bIn.valid) begin
            for (int p = 0; p < PIXEL_NUM; p++) begin
                for (int b = 0; b < BIN_NUM; b++) begin
                    if (bIn.pixel == PIXEL_W'(p) && bIn.bin == BIN_W'(b) &&
                        counts[p][b] != COUNT_MAX) begin
                        counts[p][b] <= counts[p][b] + 1'b1; // stops at 255
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN || clear) begin
            frameDone <= 1'b0;
        end else begin
            frameDone <= bIn.valid && bIn.frameEnd;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // read port
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // an address outside the array reads as zero
    always_comb begin
        rdValue = '0;
        for (int p = 0; p < PIXEL_NUM; p++) begin
            for (int b = 0; b < BIN_NUM; b++) begin
                if (rdPixel == PIXEL_W'(p) && rdBin == BIN_W'(b)) begin
                    rdValue = counts[p][b];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            rdCount <= '0;
        end else begin
            rdCount <= rdValue; // one cycle read latency
        end
    end

endmodule

`default_nettype wire

// File: source/binClassifier.sv
`timescale 1ns/10ps
`default_nettype none

module binClassifier import hisPkg::*; (
    input  wire clk,
    input  wire rstN,
    pixelIf.dst pIn,
    binIf.src   bOut
);

    logic [BIN_W-1:0] binIdx;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // edge compare
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // edges ascend, so the number of edges reached is the bin index
    // all seven compares run in parallel and feed one adder tree
    always_comb begin
        binIdx = '0;
        for (int e = 0; e < BIN_NUM - 1; e++) begin
            if (pIn.energy >= BIN_EDGES[e]) begin
                binIdx = binIdx + 1'b1;
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // output register
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (!rstN) begin
            bOut.valid <= 1'b0;
        end else begin
            bOut.valid <= pIn.valid; // one cycle behind pixelIf
        end
    end

    always_ff @(posedge clk) begin
        if (pIn.valid) begin
            bOut.bin      <= binIdx;
            bOut.pixel    <= pIn.pixel;
            bOut.frameEnd <= pIn.frameEnd;
        end
    end

endmodule

`default_nettype wire

// File: source/sampleSequencer.sv
`timescale 1ns/10ps
`default_nettype none

module sampleSequencer import hisPkg::*; (
    input  wire            clk,
    input  wire            rstN,
    input  wire            clear,
    input  wire            wrEn,
    input  wire [NP-1:0]   data,
    pixelIf.src            pOut
);

    logic               phase;       // 0 = waiting for first sample
    logic [PIXEL_W-1:0] pixelCnt;
    logic [NP-1:0]      firstSample; // held until its partner arrives
    logic               lastSample;
    logic               lastPixel;

    assign lastSample = (phase == 1'(SAMPLES_PER_PIXEL - 1));
    assign lastPixel  = (pixelCnt == PIXEL_W'(PIXEL_NUM - 1));

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // sample order
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (!rstN || clear) begin // clear beats a coincident wrEn
            phase      <= 1'b0;
            pixelCnt   <= '0;
            pOut.valid <= 1'b0;
        end else begin
            pOut.valid <= 1'b0;
            if (wrEn) begin
                if (lastSample) begin
                    phase      <= 1'b0;
                    pOut.valid <= 1'b1;
                    // wrap back to pixel 0 after the frame
                    if (lastPixel) begin
                        pixelCnt <= '0;
                    end else begin
                        pixelCnt <= pixelCnt + 1'b1;
                    end
                end else begin
                    phase <= 1'b1;
                end
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // pairing and sum
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (wrEn && !lastSample) begin
            firstSample <= data;
        end
        if (wrEn && lastSample) begin
            pOut.energy   <= ENERGY_W'(firstSample) + ENERGY_W'(data);
            pOut.pixel    <= pixelCnt;
            pOut.frameEnd <= lastPixel;
        end
    end

endmodule

`default_nettype wire

// File: source/binIf.sv
`timescale 1ns/10ps
`default_nettype none

// classified hit, classifier to accumulator
interface binIf import hisPkg::*; ();

    logic               valid;    // one-cycle strobe
    logic [PIXEL_W-1:0] pixel;
    logic [BIN_W-1:0]   bin;
    logic               frameEnd; // carried along from pixelIf

    modport src (output valid, output pixel, output bin, output frameEnd);

    modport dst (input valid, input pixel, input bin, input frameEnd);

endinterface

`default_nettype wire

// File: source/pixelIf.sv
`timescale 1ns/10ps
`default_nettype none

// paired energy of one pixel, sequencer to classifier
interface pixelIf import hisPkg::*; ();

    logic                valid;    // one-cycle strobe
    logic [PIXEL_W-1:0]  pixel;
    logic [ENERGY_W-1:0] energy;
    logic                frameEnd; // last pixel of the frame

    modport src (output valid, output pixel, output energy, output frameEnd);

    modport dst (input valid, input pixel, input energy, input frameEnd);

endinterface

`default_nettype wire

// File: source/hisPkg.sv
`default_nettype none

package hisPkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // sample and pixel sizes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int NP                = 10; // raw sample width
    localparam int PIXEL_NUM         = 3;  // pixels per frame
    localparam int SAMPLES_PER_PIXEL = 2;
    localparam int PIXEL_W           = 2;
    localparam int ENERGY_W          = NP + 1; // sum of two samples

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // energy bins
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int BIN_NUM = 8;
    localparam int BIN_W   = 3;

    // lower edges of bins 1..7, entry 0 sits in the low bits
    // bin 0 takes everything below the first edge
    localparam logic [BIN_NUM-2:0][ENERGY_W-1:0] BIN_EDGES = {
        11'd1536,
        11'd1024,
        11'd768,
        11'd512,
        11'd384,
        11'd256,
        11'd128
    };

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // histogram counters
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int COUNT_W = 8;
    localparam logic [COUNT_W-1:0] COUNT_MAX = '1; // saturation value, 255

endpackage

`default_nettype wire
